/* design/acc_cpu_pkg.sv */
package acc_cpu_pkg;

	typedef logic [7:0] word_t; // data, instruction and address byte

	// -------------------
	// instruction set, low six bits of the instruction byte
	typedef enum logic [5:0]
	{
		OP_LDAC  = 6'd1,
		OP_MVACR = 6'd4,
		OP_ADD   = 6'd10,
		OP_STAC  = 6'd13,
		OP_MULT  = 6'd15,
		OP_SUB   = 6'd19,
		OP_CLRR  = 6'd23,
		OP_CLRAC = 6'd24,
		OP_INCAC = 6'd26,
		OP_JPNZ  = 6'd27,
		OP_ENDOP = 6'd28
	} opcode_t;

	typedef enum logic [3:0]
	{
		IDLE,
		FETCH1,
		FETCH2,
		FETCH3,
		EXEC1,
		EXEC2,
		EXEC3,
		EXEC4,
		EXEC5,
		HALT
	} seq_state_t;

	typedef enum logic [2:0]
	{
		SRC_CODE_MEM,
		SRC_DATA_MEM,
		SRC_DR,
		SRC_AC,
		SRC_R
	} bus_src_t;

	typedef enum logic [1:0]
	{
		ALU_PASS,
		ALU_ADD,
		ALU_SUB,
		ALU_MULT
	} alu_op_t;

	// -------------------
	// control word, one per cycle
	typedef struct packed
	{
		logic     ld_pc;
		logic     ld_ar;
		logic     ld_dr;
		logic     ld_ir;
		logic     ld_r;
		logic     ld_ac;
		logic     ar_from_pc; // ar source: pc instead of bus
		bus_src_t bus_src;
		alu_op_t  alu_op;
		logic     pc_inc;
		logic     ac_inc;
		logic     clr_ac;
		logic     clr_r;
		logic     dm_wr;
	} ctrl_t;

	localparam ctrl_t CTRL_NOP = '0; // all enables off, bus from code mem

	typedef struct packed
	{
		logic  en;
		logic  to_data; // 0 = code memory, 1 = data memory
		word_t addr;
		word_t data;
	} load_req_t;

	typedef struct packed
	{
		logic  valid;
		word_t addr;
		word_t data;
	} store_evt_t;

endpackage

/* design/alu.sv */
module alu import acc_cpu_pkg::*;
(
	input  alu_op_t op,
	input  word_t   a,
	input  word_t   b,
	output word_t   y
);

	always_comb
	begin
		case (op)
			ALU_PASS: y = b;
			ALU_ADD:  y = a + b; // wraps at 8 bits
			ALU_SUB:  y = a - b;
			ALU_MULT: y = a * b; // low byte of the product
			default:  y = b;
		endcase
	end

endmodule

/* design/sequencer.sv */
module sequencer import acc_cpu_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    start,
	input  opcode_t ir_op,
	input  logic    zero,
	output ctrl_t   ctrl,
	output logic    halted
);

	seq_state_t state;
	seq_state_t state_d;

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= IDLE;
		else
			state <= state_d;
	end

	assign halted = (state == HALT);

	// -------------------
	// control word per state and opcode
	always_comb
	begin
		ctrl    = CTRL_NOP;
		state_d = state;
		case (state)
			IDLE:
			begin
				if (start)
					state_d = FETCH1;
			end

			FETCH1:
			begin
				ctrl.ld_ar      = 1'b1; // ar <- pc
				ctrl.ar_from_pc = 1'b1;
				state_d         = FETCH2;
			end

			FETCH2:
			begin
				ctrl.pc_inc = 1'b1; // code mem read in flight
				state_d     = FETCH3;
			end

			FETCH3:
			begin
				ctrl.ld_ir   = 1'b1;
				ctrl.bus_src = SRC_CODE_MEM;
				state_d      = EXEC1;
			end

			EXEC1:
			begin
				state_d = FETCH1;
				case (ir_op)
					OP_LDAC, OP_STAC:
					begin
						ctrl.ld_ar      = 1'b1; // point at operand byte
						ctrl.ar_from_pc = 1'b1;
						ctrl.pc_inc     = 1'b1;
						state_d         = EXEC2;
					end
					OP_JPNZ:
					begin
						if (!zero)
						begin
							ctrl.ld_ar      = 1'b1;
							ctrl.ar_from_pc = 1'b1;
						end
						ctrl.pc_inc = 1'b1; // not taken just skips operand
						state_d     = EXEC2;
					end
					OP_MVACR:
					begin
						ctrl.ld_r    = 1'b1;
						ctrl.bus_src = SRC_AC;
					end
					OP_ADD:
					begin
						ctrl.ld_ac   = 1'b1;
						ctrl.bus_src = SRC_R;
						ctrl.alu_op  = ALU_ADD;
					end
					OP_SUB:
					begin
						ctrl.ld_ac   = 1'b1;
						ctrl.bus_src = SRC_R;
						ctrl.alu_op  = ALU_SUB;
					end
					OP_MULT:
					begin
						ctrl.ld_ac   = 1'b1;
						ctrl.bus_src = SRC_R;
						ctrl.alu_op  = ALU_MULT;
					end
					OP_CLRR:  ctrl.clr_r  = 1'b1;
					OP_CLRAC: ctrl.clr_ac = 1'b1;
					OP_INCAC: ctrl.ac_inc = 1'b1;
					OP_ENDOP: state_d     = HALT;
					default:  state_d     = FETCH1; // no-op
				endcase
			end

			EXEC2:
			begin
				// ac is untouched since EXEC1, so zero still holds the branch decision
				if (ir_op == OP_JPNZ && zero)
					state_d = FETCH1;
				else
					state_d = EXEC3; // operand read in flight
			end

			EXEC3:
			begin
				ctrl.bus_src = SRC_CODE_MEM;
				if (ir_op == OP_JPNZ)
					ctrl.ld_dr = 1'b1; // jump target
				else
					ctrl.ld_ar = 1'b1; // data address
				state_d = EXEC4;
			end

			EXEC4:
			begin
				state_d = FETCH1;
				case (ir_op)
					OP_JPNZ:
					begin
						ctrl.ld_pc   = 1'b1;
						ctrl.bus_src = SRC_DR;
					end
					OP_STAC:
					begin
						ctrl.dm_wr   = 1'b1;
						ctrl.bus_src = SRC_AC;
					end
					default: state_d = EXEC5; // ldac, data read in flight
				endcase
			end

			EXEC5:
			begin
				ctrl.ld_ac   = 1'b1;
				ctrl.bus_src = SRC_DATA_MEM;
				ctrl.alu_op  = ALU_PASS;
				state_d      = FETCH1;
			end

			HALT: state_d = HALT; // only rst leaves

			default: state_d = IDLE;
		endcase
	end

endmodule

/* design/datapath.sv */
module datapath import acc_cpu_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  ctrl_t   ctrl,
	input  word_t   code_rdata,
	input  word_t   data_rdata,
	output word_t   ar,
	output word_t   bus_out,
	output opcode_t ir_op,
	output logic    zero,
	output word_t   ac
);

	word_t pc;
	word_t dr;
	word_t ir;
	word_t r;
	word_t alu_y;

	// -------------------
	// internal bus
	always_comb
	begin
		case (ctrl.bus_src)
			SRC_CODE_MEM: bus_out = code_rdata;
			SRC_DATA_MEM: bus_out = data_rdata;
			SRC_DR:       bus_out = dr;
			SRC_AC:       bus_out = ac;
			SRC_R:        bus_out = r;
			default:      bus_out = '0;
		endcase
	end

	alu u_alu
	(
		.op (ctrl.alu_op),
		.a  (ac),
		.b  (bus_out),
		.y  (alu_y)
	);

	// -------------------
	// registers
	always_ff @(posedge clk)
	begin
		if (rst)
			pc <= '0;
		else if (ctrl.ld_pc)
			pc <= bus_out; // jump
		else if (ctrl.pc_inc)
			pc <= pc + 8'd1;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			ac <= '0;
		else if (ctrl.clr_ac)
			ac <= '0;
		else if (ctrl.ld_ac)
			ac <= alu_y;
		else if (ctrl.ac_inc)
			ac <= ac + 8'd1;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			r <= '0;
		else if (ctrl.clr_r)
			r <= '0;
		else if (ctrl.ld_r)
			r <= bus_out;
	end

	always_ff @(posedge clk)
	begin
		if (ctrl.ld_ar)
			ar <= ctrl.ar_from_pc ? pc : bus_out;
		if (ctrl.ld_dr)
			dr <= bus_out;
		if (ctrl.ld_ir)
			ir <= bus_out;
	end

	assign ir_op = opcode_t'(ir[5:0]); // top two bits ignored
	assign zero  = (ac == '0);

endmodule

/* design/code_ram.sv */
module code_ram import acc_cpu_pkg::*;
#(
	parameter int MEM_ADDR_W = 8
)
(
	input  logic      clk,
	input  load_req_t load,
	input  word_t     addr,
	output word_t     rdata
);

	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

	word_t     mem [2**MEM_ADDR_W];
	mem_addr_t rd_addr;
	mem_addr_t ld_addr;

	assign rd_addr = addr[MEM_ADDR_W-1:0];
	assign ld_addr = load.addr[MEM_ADDR_W-1:0];

	always_ff @(posedge clk)
	begin
		if (load.en && !load.to_data)
			mem[ld_addr] <= load.data; // program image
		rdata <= mem[rd_addr];
	end

endmodule

/* design/data_ram.sv */
module data_ram import acc_cpu_pkg::*;
#(
	parameter int MEM_ADDR_W = 8
)
(
	input  logic       clk,
	input  logic       rst,
	input  load_req_t  load,
	input  word_t      addr,
	input  word_t      wdata,
	input  logic       wr,
	output word_t      rdata,
	output store_evt_t store
);

	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

	word_t     mem [2**MEM_ADDR_W];
	mem_addr_t rd_addr;
	mem_addr_t ld_addr;
	logic      store_valid;
	word_t     store_addr;
	word_t     store_data;

	assign rd_addr = addr[MEM_ADDR_W-1:0];
	assign ld_addr = load.addr[MEM_ADDR_W-1:0];

	always_ff @(posedge clk)
	begin
		if (wr)
			mem[rd_addr] <= wdata; // stac
		else if (load.en && load.to_data)
			mem[ld_addr] <= load.data;
		rdata <= mem[rd_addr];
	end

	// -------------------
	// store event, one cycle after the write strobe
	always_ff @(posedge clk)
	begin
		if (rst)
			store_valid <= 1'b0;
		else
			store_valid <= wr;
	end

	always_ff @(posedge clk)
	begin
		if (wr)
		begin
			store_addr <= addr;
			store_data <= wdata;
		end
	end

	assign store = '{valid: store_valid, addr: store_addr, data: store_data};

endmodule

/* design/acc_cpu.sv */
module acc_cpu import acc_cpu_pkg::*;
#(
	parameter int MEM_ADDR_W = 8
)
(
	input  logic       clk,
	input  logic       rst,
	input  load_req_t  load, // only while idle or halted
	input  logic       start,
	output logic       halted,
	output word_t      ac,
	output store_evt_t store
);

	ctrl_t   ctrl;
	opcode_t ir_op;
	logic    zero;
	word_t   ar;
	word_t   bus_out;
	word_t   code_rdata;
	word_t   data_rdata;

	sequencer u_sequencer
	(
		.clk    (clk),
		.rst    (rst),
		.start  (start),
		.ir_op  (ir_op),
		.zero   (zero),
		.ctrl   (ctrl),
		.halted (halted)
	);

	datapath u_datapath
	(
		.clk        (clk),
		.rst        (rst),
		.ctrl       (ctrl),
		.code_rdata (code_rdata),
		.data_rdata (data_rdata),
		.ar         (ar),
		.bus_out    (bus_out),
		.ir_op      (ir_op),
		.zero       (zero),
		.ac         (ac)
	);

	// -------------------
	// memories share ar as address
	code_ram #(.MEM_ADDR_W(MEM_ADDR_W)) u_code_ram
	(
		.clk   (clk),
		.load  (load),
		.addr  (ar),
		.rdata (code_rdata)
	);

	data_ram #(.MEM_ADDR_W(MEM_ADDR_W)) u_data_ram
	(
		.clk   (clk),
		.rst   (rst),
		.load  (load),
		.addr  (ar),
		.wdata (bus_out), // ac during stac
		.wr    (ctrl.dm_wr),
		.rdata (data_rdata),
		.store (store)
	);

endmodule

/* testbench/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// --------------------
// program and data images, shared by loader and model
word_t       code_img [256];
word_t       data_img [256];
int          prog_len;
logic [15:0] exp_stores [$]; // {addr, data} per stac

function automatic void clear_images();
	prog_len = 0;
	exp_stores.delete();
	for (int i = 0; i < 256; i++)
	begin
		code_img[8'(i)] = 8'h00;
		data_img[8'(i)] = 8'(i * 37 + 91); // distinct byte per address
	end
endfunction

function automatic void emit(input word_t b);
	code_img[8'(prog_len)] = b;
	prog_len++;
endfunction

function automatic void emit_op(input opcode_t op);
	emit({2'b00, op});
endfunction

function automatic void emit_addr(input opcode_t op, input word_t a);
	emit_op(op);
	emit(a); // operand byte follows opcode
endfunction

// --------------------
// instruction-level interpreter, fills exp_stores and returns final ac
function automatic word_t run_model();
	word_t dm [256];
	word_t pc;
	word_t acc;
	word_t r;
	word_t op_byte;
	word_t opnd;
	int    steps;
	bit    running;
	dm      = data_img;
	pc      = '0;
	acc     = '0;
	r       = '0;
	steps   = 0;
	running = 1'b1;
	exp_stores.delete();
	while (running && steps < 4096)
	begin
		op_byte = code_img[pc];
		opnd    = code_img[pc + 8'd1];
		pc      = pc + 8'd1;
		steps++;
		case (op_byte[5:0]) // top two bits ignored
			OP_LDAC:
			begin
				acc = dm[opnd];
				pc  = pc + 8'd1;
			end
			OP_STAC:
			begin
				dm[opnd] = acc;
				exp_stores.push_back({opnd, acc});
				pc = pc + 8'd1;
			end
			OP_MVACR: r   = acc;
			OP_ADD:   acc = acc + r; // 8-bit wrap
			OP_SUB:   acc = acc - r;
			OP_MULT:  acc = acc * r; // low byte only
			OP_CLRR:  r   = '0;
			OP_CLRAC: acc = '0;
			OP_INCAC: acc = acc + 8'd1;
			OP_JPNZ:  pc  = (acc != '0) ? opnd : pc + 8'd1;
			OP_ENDOP: running = 1'b0;
			default:  ; // no-op
		endcase
	end
	return acc;
endfunction

// --------------------
// programs used by several tests
function automatic void build_arith(input word_t x, input word_t y);
	clear_images();
	data_img[8'h10] = x;
	data_img[8'h11] = y;
	emit_addr(OP_LDAC, 8'h10);
	emit_op(OP_MVACR);
	emit_addr(OP_LDAC, 8'h11);
	emit_op(OP_ADD);
	emit_addr(OP_STAC, 8'h20);
	emit_op(OP_SUB);
	emit_addr(OP_STAC, 8'h21);
	emit_op(OP_MULT);
	emit_addr(OP_STAC, 8'h22);
	emit_op(OP_ENDOP);
endfunction

function automatic void build_countdown(input word_t count);
	word_t top;
	clear_images();
	data_img[8'h10] = count;
	emit_op(OP_CLRAC);
	emit_op(OP_INCAC);
	emit_op(OP_MVACR); // r = 1
	emit_addr(OP_LDAC, 8'h10);
	top = 8'(prog_len);
	emit_op(OP_SUB);
	emit_addr(OP_STAC, 8'h20);
	emit_addr(OP_JPNZ, top);
	emit_op(OP_ENDOP);
endfunction

`endif

/* testbench/tb_acc_cpu.sv */
module tb_acc_cpu import acc_cpu_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	logic       clk;
	logic       rst;
	logic       start;
	load_req_t  load;
	logic       halted;
	word_t      ac;
	store_evt_t store;

	logic [15:0] got_stores [$];
	word_t       exp_ac;
	bit          cmp_req;
	int          check_count;
	int          error_count;
	integer      seed;

	`include "tb_ref_model.svh"

	acc_cpu #(.MEM_ADDR_W(8)) u_acc_cpu
	(
		.clk    (clk),
		.rst    (rst),
		.load   (load),
		.start  (start),
		.halted (halted),
		.ac     (ac),
		.store  (store)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
	begin
		if (store.valid)
			got_stores.push_back({store.addr, store.data});
	end

	task automatic check_value(input string what, input logic [15:0] got,
		input logic [15:0] exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	// --------------------
	// compare process, runs once per request
	initial
	begin
		cmp_req = 1'b0;
		forever
		begin
			@(posedge clk);
			if (cmp_req)
			begin
				check_value("store count", 16'(got_stores.size()), 16'(exp_stores.size()));
				for (int k = 0; k < got_stores.size() && k < exp_stores.size(); k++)
					check_value("store {addr,data}", got_stores[k], exp_stores[k]);
				check_value("final ac", 16'(ac), 16'(exp_ac));
				cmp_req = 1'b0;
			end
		end
	end

	task automatic do_reset();
		@(posedge clk);
		rst <= 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic load_byte(input logic to_dm, input word_t a, input word_t d);
		@(posedge clk);
		load <= '{en: 1'b1, to_data: to_dm, addr: a, data: d};
	endtask

	task automatic prepare_run();
		do_reset();
		for (int i = 0; i < prog_len; i++)
			load_byte(1'b0, 8'(i), code_img[8'(i)]);
		for (int i = 0; i < 256; i++)
			load_byte(1'b1, 8'(i), data_img[8'(i)]); // whole data image each run
		@(posedge clk);
		load <= '0;
		got_stores.delete();
		exp_ac = run_model();
	endtask

	task automatic pulse_start();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic wait_halted(input int limit);
		int n;
		n = 0;
		while (!halted && n < limit)
		begin
			@(posedge clk);
			n++;
		end
		if (!halted)
		begin
			error_count++;
			$display("ERROR at %0t: core did not halt within %0d cycles", $time, limit);
		end
	endtask

	task automatic wait_store(input int limit);
		int n;
		n = 0;
		while (got_stores.size() == 0 && n < limit)
		begin
			@(posedge clk);
			n++;
		end
		if (got_stores.size() == 0)
		begin
			error_count++;
			$display("ERROR at %0t: no store seen within %0d cycles", $time, limit);
		end
	endtask

	task automatic request_compare();
		int n;
		n = 0;
		cmp_req = 1'b1;
		while (cmp_req && n < 10)
		begin
			@(posedge clk);
			n++;
		end
		if (cmp_req)
		begin
			error_count++;
			$display("ERROR at %0t: compare process did not answer", $time);
		end
	endtask

	task automatic run_program();
		prepare_run();
		pulse_start();
		wait_halted(2000);
		request_compare();
	endtask

	task automatic end_test(input string name, input int errs_before);
		if (error_count == errs_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, error_count - errs_before);
	endtask

	// --------------------
	// test sequence
	initial
	begin
		int    errs;
		int    low_cycles;
		word_t x;
		word_t y;
		rst         = 1'b1;
		start       = 1'b0;
		load        = '0;
		check_count = 0;
		error_count = 0;
		seed        = 32'h3a5b_7fa9;

		errs = error_count;
		build_arith(8'd23, 8'd9);
		run_program();
		end_test("load and arithmetic", errs);

		errs = error_count;
		clear_images();
		data_img[8'h10] = 8'hfe;
		emit_addr(OP_LDAC, 8'h10);
		emit_op(OP_INCAC);
		emit_addr(OP_STAC, 8'h20);
		emit_op(OP_INCAC); // wraps to zero
		emit_addr(OP_STAC, 8'h21);
		emit_op(OP_INCAC);
		emit_op(OP_MVACR);
		emit_op(OP_CLRAC);
		emit_addr(OP_STAC, 8'h22);
		emit_op(OP_ADD);
		emit_op(OP_CLRR);
		emit_op(OP_ADD); // adds cleared r
		emit_addr(OP_STAC, 8'h23);
		emit_op(OP_ENDOP);
		run_program();
		end_test("clear and increment", errs);

		errs = error_count;
		build_countdown(8'd6);
		run_program();
		end_test("jpnz countdown loop", errs);

		errs = error_count;
		clear_images();
		emit_addr(OP_LDAC, 8'h10);
		emit(8'h00);
		emit(8'h02);
		emit(8'h3f);
		emit(8'hc5); // low bits 5, unlisted
		emit_addr(OP_STAC, 8'h20);
		emit_op(OP_ENDOP);
		emit_op(OP_INCAC); // only reached if start leaves halt
		emit_addr(OP_STAC, 8'h21);
		emit_op(OP_ENDOP);
		run_program();
		pulse_start();
		low_cycles = 0;
		repeat (20)
		begin
			@(posedge clk);
			if (!halted)
				low_cycles++;
		end
		check_value("cycles out of halt", 16'(low_cycles), 16'd0);
		check_value("stores after halt", 16'(got_stores.size()), 16'(exp_stores.size()));
		check_value("ac after halt", 16'(ac), 16'(exp_ac));
		end_test("halt and unknown opcodes", errs);

		errs = error_count;
		for (int n = 0; n < 10; n++)
		begin
			x = 8'($random(seed));
			y = 8'($random(seed));
			build_arith(x, y);
			run_program();
		end
		end_test("random operands", errs);

		errs = error_count;
		do_reset(); // core halted from the last run
		@(posedge clk);
		check_value("halted after reset", 16'(halted), 16'd0);
		build_countdown(8'd200);
		prepare_run();
		pulse_start();
		wait_store(500);
		do_reset(); // mid loop
		@(posedge clk);
		check_value("store valid after reset", 16'(store.valid), 16'd0);
		check_value("ac after reset", 16'(ac), 16'd0);
		got_stores.delete();
		repeat (40) @(posedge clk); // longer than one loop pass
		check_value("stores while idle", 16'(got_stores.size()), 16'd0);
		check_value("halted while idle", 16'(halted), 16'd0);
		end_test("reset during run", errs);

		$display("summary: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* acc_cpu.f */
+incdir+testbench
design/acc_cpu_pkg.sv
design/alu.sv
design/sequencer.sv
design/datapath.sv
design/code_ram.sv
design/data_ram.sv
design/acc_cpu.sv
testbench/tb_acc_cpu.sv

/* run.sh */
#!/bin/sh
# compile and run the acc_cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timescale 1ns/1ps --top-module tb_acc_cpu \
	-f acc_cpu.f -o tb_acc_cpu
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_acc_cpu > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "CHECKS FAILED" "$log"; then
	exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$log"; then
	echo "no pass line found in $log"
	exit 1
fi
exit 0
